/* Makefile */
TOP = line_fetch_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -o $(TOP)

run: build
	./obj_dir/$(TOP) +verilator+error+limit+100 > sim.log 2>&1; status=$$?; \
	cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "TEST FAILED" sim.log; then exit 1; fi

lint:
	verilator --lint-only -Wall --timing -f filelist.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

/* filelist.f */
src/line_fetch_pkg.sv
src/line_burst_gen.sv
src/axi_line_reader.sv
src/line_buffer_fifo.sv
src/line_fetch_top.sv
tb/line_fetch_properties.sv
tb/line_fetch_checker.sv
tb/line_fetch_tb.sv

/* src/axi_line_reader.sv */
// AXI read-channel adapter, drives AR from the burst generator and hands R beats to the buffer
`timescale 1ns/100ps

module axi_line_reader
	import line_fetch_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,

	// Command
	input  fetch_cmd_t cmd,
	input  logic       cmd_req,
	output logic       cmd_ack,

	// AR channel
	output addr_t      ar_addr,
	output axi_len_t   ar_len,
	output axi_burst_t ar_burst,
	output logic       ar_valid,
	input  logic       ar_ready,

	// R channel
	input  data_t      r_data,
	input  logic       r_last,
	input  logic       r_valid,
	output logic       r_ready,

	// Buffer write side
	output logic       buf_wr,
	output buf_entry_t buf_entry,
	input  logic       buf_full
);

	logic r_fire;

	// ******************************
	// R to buffer
	// ******************************
	// Slave is stalled whenever the buffer has no room
	assign r_ready = !buf_full;
	assign r_fire  = r_valid && r_ready;

	// One entry per accepted beat, burst end carried along
	assign buf_wr         = r_fire;
	assign buf_entry.data = r_data;
	assign buf_entry.last = r_last;

	// ******************************
	// Address issue
	// ******************************
	line_burst_gen u_gen (
		.clk      (clk),
		.rst_n    (rst_n),
		.cmd      (cmd),
		.cmd_req  (cmd_req),
		.cmd_ack  (cmd_ack),
		.ar_addr  (ar_addr),
		.ar_len   (ar_len),
		.ar_burst (ar_burst),
		.ar_valid (ar_valid),
		.ar_ready (ar_ready)
	);

endmodule

/* src/line_buffer_fifo.sv */
// Synchronous FIFO of R beats, back-pressures the R channel and feeds the output stream
`timescale 1ns/100ps

module line_buffer_fifo
	import line_fetch_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,

	// Write side
	input  logic       wr,
	input  buf_entry_t wr_entry,
	output logic       full,

	// Read side, valid/ready stream
	output buf_entry_t rd_entry,
	output logic       rd_valid,
	input  logic       rd_ready
);

	// Entry storage
	buf_entry_t mem [BUF_DEPTH];

	buf_ptr_t   wr_ptr;
	buf_ptr_t   rd_ptr;
	buf_cnt_t   count;

	logic       wr_fire;
	logic       rd_fire;

	// ******************************
	// Flags
	// ******************************
	assign full     = (count == buf_cnt_t'(BUF_DEPTH));
	assign rd_valid = (count != '0);

	// Writes into a full buffer are ignored
	assign wr_fire = wr && !full;
	assign rd_fire = rd_valid && rd_ready;

	// Head entry, taken from registered storage
	assign rd_entry = mem[rd_ptr];

	// ******************************
	// Storage and pointers
	// ******************************
	always_ff @(posedge clk) begin
		if (wr_fire) begin
			mem[wr_ptr] <= wr_entry;
		end
	end

	// Pointers wrap on their own, depth is a power of two
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (wr_fire) begin
				wr_ptr <= wr_ptr + buf_ptr_t'(1);
			end
			if (rd_fire) begin
				rd_ptr <= rd_ptr + buf_ptr_t'(1);
			end
		end
	end

	// Fill level
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			count <= '0;
		end else begin
			case ({wr_fire, rd_fire})
				2'b10:   count <= count + buf_cnt_t'(1);
				2'b01:   count <= count - buf_cnt_t'(1);
				// Read and write together leave the level as is
				default: count <= count;
			endcase
		end
	end

endmodule

/* src/line_burst_gen.sv */
// Burst generator, takes a fetch command by four-phase handshake and walks its lines as AR bursts
`timescale 1ns/100ps

module line_burst_gen
	import line_fetch_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,

	// Command, four-phase req/ack
	input  fetch_cmd_t cmd,
	input  logic       cmd_req,
	output logic       cmd_ack,

	// AR channel fields
	output addr_t      ar_addr,
	output axi_len_t   ar_len,
	output axi_burst_t ar_burst,
	output logic       ar_valid,
	input  logic       ar_ready
);

	gen_state_t  state;
	gen_state_t  state_nxt;

	// Captured command and walk position
	fetch_cmd_t  cmd_r;
	addr_t       cur_addr;
	addr_t       line_addr;
	addr_t       next_line_addr;
	addr_t       burst_step;
	word_count_t words_left;
	num_lines_t  lines_left;

	// Line lengths in words, incoming and captured
	word_count_t cmd_words;
	word_count_t line_words;

	logic        start;
	logic        cmd_empty;
	logic        ar_fire;
	logic        more_in_line;
	logic        last_line;

	// ******************************
	// Decode
	// ******************************
	assign cmd_words  = word_count_t'(cmd.line_size >> WORD_SHIFT);
	assign line_words = word_count_t'(cmd_r.line_size >> WORD_SHIFT);

	// Nothing to fetch, answer the request straight away
	assign cmd_empty = (cmd_words == '0) || (cmd.num_lines == '0);

	assign start   = (state == IDLE) && cmd_req;
	assign ar_fire = ar_valid && ar_ready;

	// More than one burst left in the current line
	assign more_in_line = words_left > word_count_t'(MAX_AXI_LENGTH);
	assign last_line    = lines_left == num_lines_t'(1);

	// INCR bursts advance by a full burst, FIXED bursts stay on the address
	assign burst_step     = cmd_r.fixed_addr ? '0 : addr_t'(BURST_BYTES);
	assign next_line_addr = line_addr + cmd_r.stride;

	// ******************************
	// AR outputs
	// ******************************
	assign ar_valid = (state == ISSUE) || (state == WAIT_AR);
	assign ar_addr  = cur_addr;
	assign ar_burst = cmd_r.fixed_addr ? AXI_BURST_FIXED : AXI_BURST_INCR;

	// Full burst, or the remainder closing the line
	always_comb begin
		if (more_in_line) begin
			ar_len = axi_len_t'(MAX_AXI_LENGTH - 1);
		end else begin
			ar_len = axi_len_t'(words_left - word_count_t'(1));
		end
	end

	// Ack is held through DONE until the client drops req
	assign cmd_ack = (state == DONE);

	// ******************************
	// FSM
	// ******************************
	always_comb begin
		state_nxt = state;
		case (state)
			IDLE: begin
				if (cmd_req) begin
					state_nxt = cmd_empty ? DONE : ISSUE;
				end
			end
			ISSUE, WAIT_AR: begin
				if (ar_fire) begin
					// Last burst of the last line ends address issue
					if (!more_in_line && last_line) begin
						state_nxt = DONE;
					end else begin
						state_nxt = ISSUE;
					end
				end else begin
					state_nxt = WAIT_AR;
				end
			end
			DONE: begin
				if (!cmd_req) begin
					state_nxt = IDLE;
				end
			end
			default: state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	// Word and line counters
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			words_left <= '0;
			lines_left <= '0;
		end else if (start) begin
			words_left <= cmd_words;
			lines_left <= cmd.num_lines;
		end else if (ar_fire) begin
			if (more_in_line) begin
				words_left <= words_left - word_count_t'(MAX_AXI_LENGTH);
			end else begin
				// Reload for the next line
				words_left <= line_words;
				lines_left <= lines_left - num_lines_t'(1);
			end
		end
	end

	// Command copy and addresses
	always_ff @(posedge clk) begin
		if (start) begin
			cmd_r     <= cmd;
			cur_addr  <= cmd.base_addr;
			line_addr <= cmd.base_addr;
		end else if (ar_fire) begin
			if (more_in_line) begin
				cur_addr <= cur_addr + burst_step;
			end else begin
				// Next line starts one stride further on
				line_addr <= next_line_addr;
				cur_addr  <= next_line_addr;
			end
		end
	end

endmodule

/* src/line_fetch_pkg.sv */
// Shared widths, types and AXI constants of the line fetcher, imported by every module
package line_fetch_pkg;

	// ******************************
	// Widths
	// ******************************
	localparam int ADDR_W       = 32;
	localparam int DATA_W       = 32;
	localparam int LINE_SIZE_W  = 16;
	localparam int NUM_LINES_W  = 8;
	localparam int AXI_LEN_W    = 8;
	localparam int AXI_BURST_W  = 2;

	// Bytes per R beat, ARSIZE is fixed at 4 bytes
	localparam int BYTES_PER_BEAT = 4;
	localparam int WORD_SHIFT     = $clog2(BYTES_PER_BEAT);
	// Word count of a line, line size without the byte offset bits
	localparam int WORD_COUNT_W   = LINE_SIZE_W - WORD_SHIFT;

	// Longest burst in beats and its span in bytes
	localparam int MAX_AXI_LENGTH = 16;
	localparam int BURST_BYTES    = MAX_AXI_LENGTH * BYTES_PER_BEAT;

	// Output buffer geometry
	localparam int BUF_DEPTH = 8;
	localparam int BUF_PTR_W = $clog2(BUF_DEPTH);
	localparam int BUF_CNT_W = $clog2(BUF_DEPTH + 1);

	// ******************************
	// Plain vector types
	// ******************************
	typedef logic [ADDR_W-1:0]       addr_t;
	typedef logic [DATA_W-1:0]       data_t;
	typedef logic [LINE_SIZE_W-1:0]  line_size_t;
	typedef logic [NUM_LINES_W-1:0]  num_lines_t;
	typedef logic [WORD_COUNT_W-1:0] word_count_t;
	typedef logic [AXI_LEN_W-1:0]    axi_len_t;
	typedef logic [AXI_BURST_W-1:0]  axi_burst_t;
	typedef logic [BUF_PTR_W-1:0]    buf_ptr_t;
	typedef logic [BUF_CNT_W-1:0]    buf_cnt_t;

	// AXI burst type encodings
	localparam axi_burst_t AXI_BURST_FIXED = 2'd0;
	localparam axi_burst_t AXI_BURST_INCR  = 2'd1;

	// ******************************
	// Structs and state
	// ******************************
	// One fetch command as handed over by the client
	typedef struct packed {
		addr_t      base_addr;
		line_size_t line_size;
		num_lines_t num_lines;
		addr_t      stride;
		logic       fixed_addr;
	} fetch_cmd_t;

	// One buffered R beat, last marks the end of an AXI burst
	typedef struct packed {
		data_t data;
		logic  last;
	} buf_entry_t;

	// Burst generator FSM
	typedef enum logic [1:0] {
		IDLE,
		ISSUE,
		WAIT_AR,
		DONE
	} gen_state_t;

endpackage

/* src/line_fetch_top.sv */
// Top level of the line fetcher, command and AXI read ports in, word stream out
`timescale 1ns/100ps

module line_fetch_top
	import line_fetch_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,

	// Command, four-phase req/ack
	input  fetch_cmd_t cmd,
	input  logic       cmd_req,
	output logic       cmd_ack,

	// AXI AR channel
	output addr_t      ar_addr,
	output axi_len_t   ar_len,
	output axi_burst_t ar_burst,
	output logic       ar_valid,
	input  logic       ar_ready,

	// AXI R channel
	input  data_t      r_data,
	input  logic       r_last,
	input  logic       r_valid,
	output logic       r_ready,

	// Output word stream
	output buf_entry_t out_entry,
	output logic       out_valid,
	input  logic       out_ready
);

	// Reader to buffer
	logic       buf_wr;
	buf_entry_t buf_entry;
	logic       buf_full;

	axi_line_reader u_reader (
		.clk       (clk),
		.rst_n     (rst_n),
		.cmd       (cmd),
		.cmd_req   (cmd_req),
		.cmd_ack   (cmd_ack),
		.ar_addr   (ar_addr),
		.ar_len    (ar_len),
		.ar_burst  (ar_burst),
		.ar_valid  (ar_valid),
		.ar_ready  (ar_ready),
		.r_data    (r_data),
		.r_last    (r_last),
		.r_valid   (r_valid),
		.r_ready   (r_ready),
		.buf_wr    (buf_wr),
		.buf_entry (buf_entry),
		.buf_full  (buf_full)
	);

	line_buffer_fifo u_buf (
		.clk      (clk),
		.rst_n    (rst_n),
		.wr       (buf_wr),
		.wr_entry (buf_entry),
		.full     (buf_full),
		.rd_entry (out_entry),
		.rd_valid (out_valid),
		.rd_ready (out_ready)
	);

endmodule

/* tb/line_fetch_checker.sv */
// Testbench monitor, expands each accepted command into expected words and checks the stream
`timescale 1ns/100ps

module line_fetch_checker
	import line_fetch_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  fetch_cmd_t cmd,
	input  logic       cmd_req,
	input  buf_entry_t out_entry,
	input  logic       out_valid,
	input  logic       out_ready,
	output int         error_count,
	output int         word_count,
	output int         cmds_done
);

	// Expected entries in order, and word totals per command
	buf_entry_t exp_q[$];
	int         cmd_words_q[$];

	logic req_q = 1'b0;
	int   errs = 0;
	int   words_seen = 0;
	int   cmd_idx = 0;
	int   cmd_word = 0;
	int   cmd_errs = 0;

	// Lines split into 16-beat bursts, remainder closes the line
	task automatic expand_command(input fetch_cmd_t c);
		addr_t      burst_addr;
		addr_t      beat_addr;
		buf_entry_t e;
		int         words;
		int         done;
		int         n;
		words = int'(c.line_size) / BYTES_PER_BEAT;
		for (int l = 0; l < int'(c.num_lines); l++) begin
			burst_addr = c.base_addr + addr_t'(l) * c.stride;
			done = 0;
			while (done < words) begin
				n = (words - done > MAX_AXI_LENGTH) ? MAX_AXI_LENGTH : words - done;
				for (int b = 0; b < n; b++) begin
					// FIXED bursts repeat one address
					beat_addr = c.fixed_addr ? burst_addr
						: burst_addr + addr_t'(b * BYTES_PER_BEAT);
					e.data = beat_addr ^ 32'h5a5a_0000;
					e.last = (b == n - 1);
					exp_q.push_back(e);
				end
				done += n;
				if (!c.fixed_addr) begin
					burst_addr = burst_addr + addr_t'(BURST_BYTES);
				end
			end
		end
		cmd_words_q.push_back(words * int'(c.num_lines));
	endtask

	task automatic check_word(input buf_entry_t got);
		buf_entry_t exp;
		words_seen++;
		if (exp_q.size() == 0) begin
			$display("Output word %h arrived with no command pending", got.data);
			errs++;
		end else begin
			exp = exp_q.pop_front();
			if (got !== exp) begin
				$display("** Error cmd%0d word %0d: expected %h last %b, actual %h last %b",
					cmd_idx, cmd_word, exp.data, exp.last, got.data, got.last);
				errs++;
				cmd_errs++;
			end
			cmd_word++;
			// Command finished, one line per command
			if (cmd_word == cmd_words_q[0]) begin
				$display("cmd%0d done: %0d words, %0d mismatches", cmd_idx, cmd_word, cmd_errs);
				void'(cmd_words_q.pop_front());
				cmd_idx++;
				cmd_word = 0;
				cmd_errs = 0;
			end
		end
	endtask

	// ******************************
	// Monitor
	// ******************************
	always @(posedge clk) begin
		if (rst_n) begin
			// New command seen on the rising req
			if (cmd_req && !req_q) begin
				expand_command(cmd);
			end
			req_q = cmd_req;
			if (out_valid && out_ready) begin
				check_word(out_entry);
			end
		end
		error_count <= errs;
		word_count  <= words_seen;
		cmds_done   <= cmd_idx;
	end

endmodule

/* tb/line_fetch_properties.sv */
// Bound assertions on the AXI line reader, checks the command handshake and AR channel rules
`timescale 1ns/100ps

module line_fetch_properties
	import line_fetch_pkg::*;
(
	input logic       clk,
	input logic       rst_n,
	input logic       cmd_req,
	input logic       cmd_ack,
	input addr_t      ar_addr,
	input axi_len_t   ar_len,
	input axi_burst_t ar_burst,
	input logic       ar_valid,
	input logic       ar_ready
);

	// Failure count, read by the testbench top
	int assert_failures = 0;

	// Ack only answers a live request
	ack_after_req: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(cmd_ack) |-> $past(cmd_req))
		else begin
			$error("cmd_ack rose without cmd_req");
			assert_failures++;
		end

	// Ack held until the client drops req
	ack_held: assert property (@(posedge clk) disable iff (!rst_n)
		cmd_ack && cmd_req |=> cmd_ack)
		else begin
			$error("cmd_ack fell while cmd_req was still high");
			assert_failures++;
		end

	// AR fields frozen while the slave stalls
	ar_stable: assert property (@(posedge clk) disable iff (!rst_n)
		ar_valid && !ar_ready |=> ar_valid && $stable(ar_addr) && $stable(ar_len)
			&& $stable(ar_burst))
		else begin
			$error("AR request changed or dropped before ar_ready");
			assert_failures++;
		end

endmodule

/* tb/line_fetch_tb.sv */
// Testbench top, drives random fetch commands, models the AXI read slave and gives the verdict
`timescale 1ns/100ps

module line_fetch_tb
	import line_fetch_pkg::*;
();

	localparam int NUM_CMDS     = 40;
	localparam int RESET_CYCLES = 8;

	// One queued AR request of the slave
	typedef struct packed {
		addr_t      addr;
		axi_len_t   len;
		axi_burst_t burst;
	} ar_req_t;

	logic       clk = 1'b0;
	logic       rst_n = 1'b0;
	fetch_cmd_t cmd = '0;
	logic       cmd_req = 1'b0;
	logic       cmd_ack;
	addr_t      ar_addr;
	axi_len_t   ar_len;
	axi_burst_t ar_burst;
	logic       ar_valid;
	logic       ar_ready = 1'b0;
	data_t      r_data = '0;
	logic       r_last = 1'b0;
	logic       r_valid = 1'b0;
	logic       r_ready;
	buf_entry_t out_entry;
	logic       out_valid;
	logic       out_ready = 1'b0;

	fetch_cmd_t  cmds [NUM_CMDS];
	// Extra cycles each request stays up after its ack
	int          holds [NUM_CMDS];
	ar_req_t     ar_q[$];
	logic [31:0] lcg_state = 32'h55e7c6f3;
	int          beat_idx = 0;
	int          total_words = 0;
	int          timeout_limit = 0;
	int          cycle_count = 0;
	int          tb_errors = 0;
	int          chk_errors;
	int          checked_words;
	int          cmds_done;

	always #5 clk = ~clk;

	line_fetch_top DUT (.*);

	line_fetch_checker u_checker (
		.clk         (clk),
		.rst_n       (rst_n),
		.cmd         (cmd),
		.cmd_req     (cmd_req),
		.out_entry   (out_entry),
		.out_valid   (out_valid),
		.out_ready   (out_ready),
		.error_count (chk_errors),
		.word_count  (checked_words),
		.cmds_done   (cmds_done)
	);

	bind axi_line_reader line_fetch_properties u_props (
		.clk(clk), .rst_n(rst_n), .cmd_req(cmd_req), .cmd_ack(cmd_ack),
		.ar_addr(ar_addr), .ar_len(ar_len), .ar_burst(ar_burst), .ar_valid(ar_valid),
		.ar_ready(ar_ready)
	);

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic int unsigned rand_below(input int unsigned n);
		return next_rand() % n;
	endfunction

	// Random commands, timeout budget summed along the way
	task automatic make_commands();
		fetch_cmd_t c;
		int         words;
		timeout_limit = RESET_CYCLES + 100;
		for (int i = 0; i < NUM_CMDS; i++) begin
			c.base_addr  = next_rand() & 32'hffff_fffc;
			c.line_size  = line_size_t'((rand_below(40) + 1) * 4);
			c.num_lines  = num_lines_t'(rand_below(6) + 1);
			c.stride     = addr_t'(rand_below(256) * 4);
			c.fixed_addr = (i % 4 == 3);
			cmds[i] = c;
			holds[i] = int'(rand_below(4));
			words = int'(c.line_size) / BYTES_PER_BEAT * int'(c.num_lines);
			total_words += words;
			timeout_limit += words * 30 + 100;
		end
	endtask

	// Four-phase handshake, req held a few random cycles past ack
	task automatic run_command(input int idx);
		@(posedge clk);
		#1;
		if (cmd_ack) begin
			$display("cmd_ack was still high when cmd%0d was requested", idx);
			tb_errors++;
		end
		cmd = cmds[idx];
		cmd_req = 1'b1;
		do begin
			@(posedge clk);
			#1;
		end while (!cmd_ack);
		repeat (holds[idx]) begin
			@(posedge clk);
			#1;
			if (!cmd_ack) begin
				$display("cmd_ack dropped while cmd%0d request was held", idx);
				tb_errors++;
			end
		end
		cmd_req = 1'b0;
		cmd = '0;
		do begin
			@(posedge clk);
			#1;
		end while (cmd_ack);
	endtask

	// ******************************
	// AXI read slave and stream sink
	// ******************************
	always @(posedge clk) begin : axi_slave
		logic  r_taken;
		addr_t beat_addr;
		r_taken = r_valid && r_ready;
		if (rst_n && ar_valid && ar_ready) begin
			ar_q.push_back('{addr: ar_addr, len: ar_len, burst: ar_burst});
		end
		if (r_taken) begin
			if (beat_idx == int'(ar_q[0].len)) begin
				void'(ar_q.pop_front());
				beat_idx = 0;
			end else begin
				beat_idx++;
			end
		end
		#1;
		ar_ready  = rand_below(4) != 0;
		out_ready = rand_below(3) != 0;
		// A presented beat stays until taken
		if (!r_valid || r_taken) begin
			if (ar_q.size() > 0 && rand_below(4) != 0) begin
				beat_addr = ar_q[0].addr;
				if (ar_q[0].burst == AXI_BURST_INCR) begin
					beat_addr = beat_addr + addr_t'(beat_idx * BYTES_PER_BEAT);
				end
				r_data  = beat_addr ^ 32'h5a5a_0000;
				r_last  = (beat_idx == int'(ar_q[0].len));
				r_valid = 1'b1;
			end else begin
				r_valid = 1'b0;
			end
		end
	end

	always @(posedge clk) begin
		if (cycle_count >= timeout_limit) begin
			$display("Timeout after %0d cycles, the word stream never completed", cycle_count);
			$display("TEST FAILED");
			$finish;
		end else begin
			cycle_count++;
		end
	end

	// ******************************
	// Main sequence
	// ******************************
	initial begin
		int errs;
		make_commands();
		repeat (RESET_CYCLES) @(posedge clk);
		if (ar_valid || cmd_ack || out_valid || !r_ready) begin
			$display("Outputs not at their idle values during reset");
			tb_errors++;
		end
		#1;
		rst_n = 1'b1;
		for (int i = 0; i < NUM_CMDS; i++) begin
			run_command(i);
		end
		while (checked_words < total_words) @(posedge clk);
		repeat (20) @(posedge clk);
		if (out_valid) begin
			$display("Buffer still holds words after the last command");
			tb_errors++;
		end
		errs = chk_errors + tb_errors + DUT.u_reader.u_props.assert_failures;
		$display("Summary: %0d of %0d commands, %0d of %0d words, %0d errors",
			cmds_done, NUM_CMDS, checked_words, total_words, errs);
		if (errs == 0 && checked_words == total_words && cmds_done == NUM_CMDS) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule
